// File: design/cpu_pkg.sv
package cpu_pkg;

    // =========================================================================
    // Widths and sizes
    // =========================================================================
    localparam int DATA_W     = 8;
    localparam int ADDR_W     = 4;
    localparam int OPC_W      = 4;
    localparam int MEM_DEPTH  = 16;
    localparam int LAST_STAGE = 5;
    localparam int CTRL_W     = 19;

    // =========================================================================
    // Control word bit positions
    // =========================================================================
    localparam int C_INP = 18;
    localparam int C_ANA = 17;
    localparam int C_XRA = 16;
    localparam int C_FE  = 15;
    localparam int C_HLT = 14;
    localparam int C_MI  = 13;
    localparam int C_RI  = 12;
    localparam int C_RO  = 11;
    localparam int C_II  = 10;
    localparam int C_IO  = 9;
    localparam int C_AI  = 8;
    localparam int C_AO  = 7;
    localparam int C_ALO = 6;
    localparam int C_SUB = 5;
    localparam int C_BI  = 4;
    localparam int C_OI  = 3;
    localparam int C_CE  = 2;
    localparam int C_CL  = 1;
    localparam int C_CO  = 0;

    // =========================================================================
    // Opcodes
    // =========================================================================
    localparam logic [OPC_W-1:0] OP_NOP = 4'd0;
    localparam logic [OPC_W-1:0] OP_LDA = 4'd1;
    localparam logic [OPC_W-1:0] OP_ADD = 4'd2;
    localparam logic [OPC_W-1:0] OP_SUB = 4'd3;
    localparam logic [OPC_W-1:0] OP_STA = 4'd4;
    localparam logic [OPC_W-1:0] OP_LDI = 4'd5;
    localparam logic [OPC_W-1:0] OP_JMP = 4'd6;
    localparam logic [OPC_W-1:0] OP_JC  = 4'd7;
    localparam logic [OPC_W-1:0] OP_JZ  = 4'd8;
    localparam logic [OPC_W-1:0] OP_ADI = 4'd9;
    localparam logic [OPC_W-1:0] OP_SUI = 4'd10;
    localparam logic [OPC_W-1:0] OP_XRA = 4'd11;
    localparam logic [OPC_W-1:0] OP_ANA = 4'd12;
    localparam logic [OPC_W-1:0] OP_INP = 4'd13;
    localparam logic [OPC_W-1:0] OP_OUT = 4'd14;
    localparam logic [OPC_W-1:0] OP_HLT = 4'd15;

    // One memory word, seen as an instruction or as a plain byte
    typedef union packed {
        struct packed {
            logic [OPC_W-1:0]  opcode;
            logic [ADDR_W-1:0] operand;
        } instr;
        logic [DATA_W-1:0] data;
    } mem_word_u;

endpackage

// File: design/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    input  logic              sub_i,
    input  logic              xra_i,
    input  logic              ana_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    output logic [DATA_W-1:0] result_o,
    output logic              carry_o,
    output logic              zero_o
);

    // Extra top bit holds carry or borrow
    logic [DATA_W:0] w;

    always_comb begin
        case ({sub_i, xra_i, ana_i})
            3'b000: begin
                w = {1'b0, a_i} + {1'b0, b_i};
            end
            3'b100: begin
                w = {1'b0, a_i} - {1'b0, b_i};
            end
            3'b010: begin
                w = {1'b0, a_i ^ b_i};
            end
            3'b001: begin
                w = {1'b0, a_i & b_i};
            end
            default: begin
                w = '0;
            end
        endcase
    end

    assign result_o = w[DATA_W-1:0];
    assign carry_o  = w[DATA_W];
    assign zero_o   = (w[DATA_W-1:0] == '0);

endmodule

// File: design/ctrl_unit.sv
`timescale 1ns/100ps

module ctrl_unit import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_i,
    input  logic              inp_loaded_i,
    input  logic [OPC_W-1:0]  opcode_i,
    input  logic              carry_i,
    input  logic              zero_i,
    output logic [CTRL_W-1:0] ctrl_o,
    output logic              inp_req_o,
    output logic              halted_o
);

    logic [2:0]        stage;
    logic              running;
    logic              waiting;
    logic              halted;
    logic [CTRL_W-1:0] word;

    // =========================================================================
    // Sequencer state
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            stage   <= '0;
            running <= 1'b0;
            waiting <= 1'b0;
            halted  <= 1'b0;
        end else if (start_i && !running && !waiting && !halted) begin
            running <= 1'b1;
            stage   <= '0;
        end else if (waiting) begin
            // Resume at stage 4 once the byte has been captured
            if (inp_loaded_i) begin
                waiting <= 1'b0;
                running <= 1'b1;
                stage   <= stage + 3'd1;
            end
        end else if (running) begin
            if (word[C_HLT]) begin
                running <= 1'b0;
                halted  <= 1'b1;
            end else if (stage == 3'd3 && opcode_i == OP_INP) begin
                running <= 1'b0;
                waiting <= 1'b1;
            end else if (stage == 3'(LAST_STAGE)) begin
                stage <= '0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // =========================================================================
    // Micro-step decode
    // =========================================================================
    always_comb begin
        word = '0;
        case (stage)
            3'd0: begin
                word[C_CO] = 1'b1;
                word[C_MI] = 1'b1;
            end
            3'd1: begin
                word[C_RO] = 1'b1;
                word[C_II] = 1'b1;
            end
            3'd2: word[C_CE] = 1'b1;
            3'd3: begin
                case (opcode_i)
                    OP_LDA, OP_STA, OP_ADD, OP_SUB, OP_XRA, OP_ANA: begin
                        word[C_IO] = 1'b1;
                        word[C_MI] = 1'b1;
                    end
                    OP_LDI: begin
                        word[C_IO] = 1'b1;
                        word[C_AI] = 1'b1;
                    end
                    OP_JMP: begin
                        word[C_IO] = 1'b1;
                        word[C_CL] = 1'b1;
                    end
                    OP_JC, OP_JZ: begin
                        // Taken only when the selected flag is set
                        if ((opcode_i == OP_JC) ? carry_i : zero_i) begin
                            word[C_IO] = 1'b1;
                            word[C_CL] = 1'b1;
                        end
                    end
                    OP_ADI, OP_SUI: begin
                        word[C_IO] = 1'b1;
                        word[C_BI] = 1'b1;
                    end
                    OP_OUT: begin
                        word[C_AO] = 1'b1;
                        word[C_OI] = 1'b1;
                    end
                    OP_HLT: word[C_HLT] = 1'b1;
                    // Idle step, INP waits here for its byte
                    OP_NOP, OP_INP: word = '0;
                    default: word = '0;
                endcase
            end
            3'd4: begin
                case (opcode_i)
                    OP_LDA: begin
                        word[C_RO] = 1'b1;
                        word[C_AI] = 1'b1;
                    end
                    OP_STA: begin
                        word[C_AO] = 1'b1;
                        word[C_RI] = 1'b1;
                    end
                    OP_ADD, OP_SUB, OP_XRA, OP_ANA: begin
                        word[C_RO] = 1'b1;
                        word[C_BI] = 1'b1;
                    end
                    OP_ADI, OP_SUI: begin
                        word[C_SUB] = (opcode_i == OP_SUI);
                        word[C_ALO] = 1'b1;
                        word[C_FE]  = 1'b1;
                        word[C_AI]  = 1'b1;
                    end
                    OP_INP: begin
                        word[C_INP] = 1'b1;
                        word[C_AI]  = 1'b1;
                    end
                    default: word = '0;
                endcase
            end
            3'd5: begin
                // Register-operand ALU ops finish here
                if (opcode_i inside {OP_ADD, OP_SUB, OP_XRA, OP_ANA}) begin
                    word[C_SUB] = (opcode_i == OP_SUB);
                    word[C_XRA] = (opcode_i == OP_XRA);
                    word[C_ANA] = (opcode_i == OP_ANA);
                    word[C_ALO] = 1'b1;
                    word[C_FE]  = 1'b1;
                    word[C_AI]  = 1'b1;
                end
            end
            default: word = '0;
        endcase
    end

    assign ctrl_o    = running ? word : '0;
    assign inp_req_o = waiting;
    assign halted_o  = halted;

    // Only one driver on the shared bus per cycle
    a_one_bus_src: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl_o[C_CO], ctrl_o[C_IO], ctrl_o[C_ALO],
                  ctrl_o[C_AO], ctrl_o[C_RO], ctrl_o[C_INP]}));

    a_wait_not_halted: assert property (@(posedge clk) disable iff (reset)
        !(inp_req_o && halted_o));

endmodule

// File: design/datapath.sv
`timescale 1ns/100ps

module datapath import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [CTRL_W-1:0] ctrl_i,
    input  logic [DATA_W-1:0] inp_data_i,
    input  logic              inp_loaded_i,
    input  mem_word_u         mem_rdata_i,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [DATA_W-1:0] mem_wdata_o,
    output logic              mem_we_o,
    output logic [OPC_W-1:0]  opcode_o,
    output logic              carry_o,
    output logic              zero_o,
    output logic [ADDR_W-1:0] pc_o,
    output logic [DATA_W-1:0] out_o
);

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] mar;
    mem_word_u         ir;
    mem_word_u         bus;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] inp_reg;
    logic [DATA_W-1:0] out_reg;
    logic              carry;
    logic              zero;
    logic [DATA_W-1:0] alu_res;
    logic              alu_carry;
    logic              alu_zero;

    alu u_alu (
        .sub_i    (ctrl_i[C_SUB]),
        .xra_i    (ctrl_i[C_XRA]),
        .ana_i    (ctrl_i[C_ANA]),
        .a_i      (a),
        .b_i      (b),
        .result_o (alu_res),
        .carry_o  (alu_carry),
        .zero_o   (alu_zero)
    );

    // =========================================================================
    // Central bus, fixed source priority
    // =========================================================================
    always_comb begin
        bus = '0;
        if (ctrl_i[C_CO]) begin
            bus.data = {{(DATA_W - ADDR_W){1'b0}}, pc};
        end else if (ctrl_i[C_IO]) begin
            bus.data = {{(DATA_W - ADDR_W){1'b0}}, ir.instr.operand};
        end else if (ctrl_i[C_ALO]) begin
            bus.data = alu_res;
        end else if (ctrl_i[C_AO]) begin
            bus.data = a;
        end else if (ctrl_i[C_RO]) begin
            bus = mem_rdata_i;
        end else if (ctrl_i[C_INP]) begin
            bus.data = inp_reg;
        end
    end

    // =========================================================================
    // Registers
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            ir      <= '0;
            a       <= '0;
            b       <= '0;
            out_reg <= '0;
            carry   <= 1'b0;
            zero    <= 1'b1;
        end else begin
            // Jump wins over increment
            if (ctrl_i[C_CL]) begin
                pc <= bus.instr.operand;
            end else if (ctrl_i[C_CE]) begin
                pc <= pc + ADDR_W'(1);
            end
            if (ctrl_i[C_II]) ir <= bus;
            if (ctrl_i[C_AI]) a <= bus.data;
            if (ctrl_i[C_BI]) b <= bus.data;
            if (ctrl_i[C_OI]) out_reg <= bus.data;
            if (ctrl_i[C_FE]) begin
                carry <= alu_carry;
                zero  <= alu_zero;
            end
        end
    end

    // Memory address and input byte
    always_ff @(posedge clk) begin
        if (ctrl_i[C_MI]) mar <= bus.instr.operand;
        if (inp_loaded_i) inp_reg <= inp_data_i;
    end

    assign mem_addr_o  = mar;
    assign mem_wdata_o = bus.data;
    assign mem_we_o    = ctrl_i[C_RI];
    assign opcode_o    = ir.instr.opcode;
    assign carry_o     = carry;
    assign zero_o      = zero;
    assign pc_o        = pc;
    assign out_o       = out_reg;

    a_no_jump_and_inc: assert property (@(posedge clk) disable iff (reset)
        !(ctrl_i[C_CL] && ctrl_i[C_CE]));

endmodule

// File: design/program_ram.sv
`timescale 1ns/100ps

module program_ram import cpu_pkg::*; (
    input  logic              clk,
    input  logic              ram_clear_i,
    input  logic              start_i,
    input  logic              load_en_i,
    input  logic [ADDR_W-1:0] load_addr_i,
    input  mem_word_u         load_data_i,
    input  logic              cpu_we_i,
    input  logic [ADDR_W-1:0] cpu_addr_i,
    input  logic [DATA_W-1:0] cpu_wdata_i,
    output mem_word_u         cpu_rdata_o
);

    mem_word_u mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (ram_clear_i) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (load_en_i && !start_i) begin
            // Manual load beats the CPU port
            mem[load_addr_i] <= load_data_i;
        end else if (cpu_we_i) begin
            mem[cpu_addr_i].data <= cpu_wdata_i;
        end
    end

    // Asynchronous read
    assign cpu_rdata_o = mem[cpu_addr_i];

    // Program loading only happens while the CPU sits idle
    a_load_vs_store: assert property (@(posedge clk)
        !(load_en_i && cpu_we_i));

endmodule

// File: design/cpu_top.sv
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              ram_clear_i,
    input  logic              start_i,
    input  logic              load_en_i,
    input  logic [ADDR_W-1:0] load_addr_i,
    input  logic [DATA_W-1:0] load_data_i,
    input  logic [DATA_W-1:0] inp_data_i,
    input  logic              inp_loaded_i,
    output logic              inp_req_o,
    output logic              halted_o,
    output logic [ADDR_W-1:0] pc_o,
    output logic [DATA_W-1:0] out_o
);

    logic [CTRL_W-1:0] ctrl;
    logic [OPC_W-1:0]  opcode;
    logic              carry;
    logic              zero;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_we;
    mem_word_u         mem_rdata;

    // =========================================================================
    // Sequencer
    // =========================================================================
    ctrl_unit u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .inp_loaded_i (inp_loaded_i),
        .opcode_i     (opcode),
        .carry_i      (carry),
        .zero_i       (zero),
        .ctrl_o       (ctrl),
        .inp_req_o    (inp_req_o),
        .halted_o     (halted_o)
    );

    // =========================================================================
    // Registers, bus and ALU
    // =========================================================================
    datapath u_dp (
        .clk          (clk),
        .reset        (reset),
        .ctrl_i       (ctrl),
        .inp_data_i   (inp_data_i),
        .inp_loaded_i (inp_loaded_i),
        .mem_rdata_i  (mem_rdata),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_we_o     (mem_we),
        .opcode_o     (opcode),
        .carry_o      (carry),
        .zero_o       (zero),
        .pc_o         (pc_o),
        .out_o        (out_o)
    );

    // Memory keeps its contents across a CPU reset
    program_ram u_ram (
        .clk          (clk),
        .ram_clear_i  (ram_clear_i),
        .start_i      (start_i),
        .load_en_i    (load_en_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .cpu_we_i     (mem_we),
        .cpu_addr_i   (mem_addr),
        .cpu_wdata_i  (mem_wdata),
        .cpu_rdata_o  (mem_rdata)
    );

endmodule

// File: sim/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 1000;

    logic              clk = 1'b0;
    logic              reset;
    logic              ram_clear;
    logic              start;
    logic              load_en;
    logic [ADDR_W-1:0] load_addr;
    mem_word_u         load_data;
    logic [DATA_W-1:0] inp_data;
    logic              inp_loaded;
    logic              inp_req;
    logic              halted;
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] out_byte;

    int                seed;
    // Program image shared by the loader and the reference model
    mem_word_u         prog [MEM_DEPTH];

    cpu_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .ram_clear_i  (ram_clear),
        .start_i      (start),
        .load_en_i    (load_en),
        .load_addr_i  (load_addr),
        .load_data_i  (load_data),
        .inp_data_i   (inp_data),
        .inp_loaded_i (inp_loaded),
        .inp_req_o    (inp_req),
        .halted_o     (halted),
        .pc_o         (pc),
        .out_o        (out_byte)
    );

    always #10 clk = ~clk;

    // ==========================================================================
    // Reporting and checks
    // ==========================================================================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                     name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                     name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %0b, actual %0b",
                                     name, exp, act));
        end
    endtask

    // ==========================================================================
    // Program building
    // ==========================================================================
    function automatic logic [ADDR_W-1:0] next_nibble();
        logic [31:0] r;
        r = $random(seed);
        return r[ADDR_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] next_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    function automatic mem_word_u encode(input logic [OPC_W-1:0] op,
                                         input logic [ADDR_W-1:0] arg);
        mem_word_u w;
        w.instr.opcode  = op;
        w.instr.operand = arg;
        return w;
    endfunction

    function automatic mem_word_u data_word(input logic [DATA_W-1:0] value);
        mem_word_u w;
        w.data = value;
        return w;
    endfunction

    task automatic clear_program();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            prog[i] = '0;
        end
    endtask

    // ==========================================================================
    // Reference model of the instruction set
    // ==========================================================================
    task automatic run_reference(input logic [DATA_W-1:0] in_byte,
                                 output logic [DATA_W-1:0] exp_out,
                                 output logic [ADDR_W-1:0] exp_pc);
        mem_word_u         m [MEM_DEPTH];
        mem_word_u         ins;
        logic [ADDR_W-1:0] pc_r;
        logic [ADDR_W-1:0] arg;
        logic [DATA_W-1:0] a_r;
        logic [DATA_W:0]   w;
        logic              c_r;
        logic              z_r;
        logic              done;
        int                steps;

        for (int i = 0; i < MEM_DEPTH; i++) begin
            m[i] = prog[i];
        end
        pc_r    = '0;
        a_r     = '0;
        exp_out = '0;
        c_r     = 1'b0;
        z_r     = 1'b1;
        done    = 1'b0;
        steps   = 0;
        while (!done) begin
            if (steps == 256) begin
                report_failure("Reference model never reached a HLT instruction");
            end
            ins  = m[pc_r];
            arg  = ins.instr.operand;
            pc_r = pc_r + ADDR_W'(1);
            w    = '0;
            steps++;
            case (ins.instr.opcode)
                OP_LDA: a_r = m[arg].data;
                OP_ADD: w = {1'b0, a_r} + {1'b0, m[arg].data};
                OP_SUB: w = {1'b0, a_r} - {1'b0, m[arg].data};
                OP_STA: m[arg].data = a_r;
                OP_LDI: a_r = {4'b0, arg};
                OP_JMP: pc_r = arg;
                OP_JC:  if (c_r) pc_r = arg;
                OP_JZ:  if (z_r) pc_r = arg;
                OP_ADI: w = {1'b0, a_r} + {5'b0, arg};
                OP_SUI: w = {1'b0, a_r} - {5'b0, arg};
                OP_XRA: w = {1'b0, a_r ^ m[arg].data};
                OP_ANA: w = {1'b0, a_r & m[arg].data};
                OP_INP: a_r = in_byte;
                OP_OUT: exp_out = a_r;
                OP_HLT: done = 1'b1;
                default: ;
            endcase
            // ALU instructions write A and both flags
            if (ins.instr.opcode inside {OP_ADD, OP_SUB, OP_ADI, OP_SUI, OP_XRA, OP_ANA}) begin
                a_r = w[DATA_W-1:0];
                c_r = w[DATA_W];
                z_r = (w[DATA_W-1:0] == '0);
            end
        end
        exp_pc = pc_r;
    endtask

    // ==========================================================================
    // DUT sequencing
    // ==========================================================================
    task automatic reset_and_check(input string name);
        @(posedge clk);
        reset     <= 1'b1;
        ram_clear <= 1'b1;
        repeat (2) @(posedge clk);
        reset     <= 1'b0;
        ram_clear <= 1'b0;
        @(negedge clk);
        check_flag(name, 1'b0, inp_req);
        check_flag(name, 1'b0, halted);
        check_data(name, 8'h00, out_byte);
        check_addr(name, 4'h0, pc);
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= ADDR_W'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        while (!halted && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            report_failure($sformatf("%s: CPU did not halt in time", name));
        end
    endtask

    task automatic wait_for_input_request(input string name);
        int cycles;
        cycles = 0;
        while (!inp_req && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!inp_req) begin
            report_failure($sformatf("%s: CPU never asked for an input byte", name));
        end
    endtask

    task automatic compare_with_reference(input string name, input logic [DATA_W-1:0] in_byte);
        logic [DATA_W-1:0] exp_out;
        logic [ADDR_W-1:0] exp_pc;
        run_reference(in_byte, exp_out, exp_pc);
        check_data(name, exp_out, out_byte);
        check_addr(name, exp_pc, pc);
    endtask

    task automatic run_to_halt(input string name);
        pulse_start();
        wait_for_halt(name);
        compare_with_reference(name, 8'h00);
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================
    task automatic immediate_ops_test();
        clear_program();
        prog[0] = encode(OP_LDI, next_nibble());
        prog[1] = encode(OP_ADI, next_nibble());
        prog[2] = encode(OP_SUI, next_nibble());
        prog[3] = encode(OP_OUT, 4'd0);
        prog[4] = encode(OP_HLT, 4'd0);
        reset_and_check("immediates");
        load_program();
        run_to_halt("immediates");
    endtask

    task automatic memory_ops_test();
        clear_program();
        prog[0]  = encode(OP_LDA, 4'd10);
        prog[1]  = encode(OP_ADD, 4'd11);
        prog[2]  = encode(OP_SUB, 4'd12);
        prog[3]  = encode(OP_STA, 4'd13);
        prog[4]  = encode(OP_LDI, 4'd0);
        prog[5]  = encode(OP_LDA, 4'd13);
        prog[6]  = encode(OP_OUT, 4'd0);
        prog[7]  = encode(OP_HLT, 4'd0);
        prog[10] = data_word(next_byte());
        prog[11] = data_word(next_byte());
        prog[12] = data_word(next_byte());
        reset_and_check("memory");
        load_program();
        run_to_halt("memory");
    endtask

    task automatic logic_ops_test();
        clear_program();
        prog[0]  = encode(OP_LDA, 4'd10);
        prog[1]  = encode(OP_XRA, 4'd11);
        prog[2]  = encode(OP_ANA, 4'd12);
        prog[3]  = encode(OP_OUT, 4'd0);
        prog[4]  = encode(OP_HLT, 4'd0);
        prog[10] = data_word(next_byte());
        prog[11] = data_word(next_byte());
        prog[12] = data_word(next_byte());
        reset_and_check("logic");
        load_program();
        run_to_halt("logic");
    endtask

    // Countdown to zero, then a taken JC after an overflowing ADI
    task automatic branch_loop_test();
        clear_program();
        // Start count of at least 2 so the JMP back is taken
        prog[0]  = encode(OP_LDI, next_nibble() | 4'd2);
        prog[1]  = encode(OP_SUI, 4'd1);
        prog[2]  = encode(OP_JZ, 4'd4);
        prog[3]  = encode(OP_JMP, 4'd1);
        prog[4]  = encode(OP_LDA, 4'd13);
        prog[5]  = encode(OP_ADI, 4'd15);
        prog[6]  = encode(OP_JC, 4'd9);
        prog[7]  = encode(OP_OUT, 4'd0);
        prog[8]  = encode(OP_HLT, 4'd0);
        prog[9]  = encode(OP_OUT, 4'd0);
        prog[10] = encode(OP_HLT, 4'd0);
        prog[13] = data_word(8'hf1 | {4'h0, next_nibble()});
        reset_and_check("branch");
        load_program();
        run_to_halt("branch");
    endtask

    task automatic input_wait_test();
        logic [DATA_W-1:0] value;
        logic [ADDR_W-1:0] stall;
        value = next_byte();
        stall = next_nibble();
        clear_program();
        prog[0] = encode(OP_INP, 4'd0);
        prog[1] = encode(OP_ADI, next_nibble());
        prog[2] = encode(OP_OUT, 4'd0);
        prog[3] = encode(OP_HLT, 4'd0);
        reset_and_check("input");
        load_program();
        pulse_start();
        wait_for_input_request("input");
        // CPU must keep waiting however long the byte takes
        repeat (stall) @(posedge clk);
        @(negedge clk);
        check_flag("input", 1'b1, inp_req);
        @(posedge clk);
        inp_data   <= value;
        inp_loaded <= 1'b1;
        @(posedge clk);
        inp_loaded <= 1'b0;
        @(negedge clk);
        check_flag("input", 1'b0, inp_req);
        wait_for_halt("input");
        compare_with_reference("input", value);
    endtask

    initial begin
        seed = 32'h216f;
        reset      <= 1'b1;
        ram_clear  <= 1'b1;
        start      <= 1'b0;
        load_en    <= 1'b0;
        load_addr  <= '0;
        load_data  <= '0;
        inp_data   <= '0;
        inp_loaded <= 1'b0;
        immediate_ops_test();
        memory_ops_test();
        logic_ops_test();
        branch_loop_test();
        input_wait_test();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: files.f
design/cpu_pkg.sv
design/alu.sv
design/ctrl_unit.sv
design/datapath.sv
design/program_ram.sv
design/cpu_top.sv
sim/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cpu -f files.f -o tb_cpu

output=$(./obj_dir/tb_cpu 2>&1 || true)
echo "$output"

if grep -q "TEST PASS" <<< "$output"; then
    exit 0
fi
exit 1
